//--- source/eth_arb_pkg.sv
package eth_arb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ethernet header fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Destination or source MAC, one word
    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] eth_type_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload beat
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [63:0] data_t;

    // One enable bit per byte lane of data_t
    typedef logic [7:0] keep_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arbitration mode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fixed priority always favours the lowest port index
    typedef enum logic {
        ARB_PRIORITY,
        ARB_ROUND_ROBIN
    } arb_type_e;

endpackage

//--- source/arbiter.sv
`timescale 1ns/1ns

module arbiter #(
    parameter int                     PORTS    = 4,
    parameter eth_arb_pkg::arb_type_e ARB_TYPE = eth_arb_pkg::ARB_PRIORITY,
    localparam int                    SEL_W    = (PORTS > 1) ? $clog2(PORTS) : 1
) (
    input  logic             clk,
    input  logic             arst_n,

    input  logic [PORTS-1:0] request,
    input  logic [PORTS-1:0] acknowledge,

    output logic [PORTS-1:0] grant,
    output logic             grant_valid,
    output logic [SEL_W-1:0] grant_index
);

    // Combinational choice among current requests
    logic             pick_valid;
    logic [SEL_W-1:0] pick_index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The loop runs from the far end down, so the last hit is the one
    // closest to the search start and takes the grant
    always_comb begin
        int unsigned idx;

        pick_valid = 1'b0;
        pick_index = '0;
        idx        = 0;
        for (int k = PORTS - 1; k >= 0; k--) begin
            if (ARB_TYPE == eth_arb_pkg::ARB_ROUND_ROBIN) begin
                // Search starts one past the last winner
                idx = (int'(grant_index) + 1 + k) % PORTS;
            end else begin
                idx = k;
            end
            if (request[idx]) begin
                pick_valid = 1'b1;
                pick_index = SEL_W'(idx);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // grant_index keeps its value after release and serves as the
    // last winner for the round-robin search
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_index <= '0;
        end else if (grant_valid) begin
            // Hold until the granted port finishes its frame
            if (|(acknowledge & grant)) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (pick_valid) begin
            grant       <= PORTS'(1) << pick_index;
            grant_valid <= 1'b1;
            grant_index <= pick_index;
        end
    end

endmodule

//--- source/eth_mux.sv
`timescale 1ns/1ns

module eth_mux #(
    parameter int  PORTS = 4,
    localparam int SEL_W = (PORTS > 1) ? $clog2(PORTS) : 1
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // Header inputs
    input  logic [PORTS-1:0]       hdr_valid,
    output logic [PORTS-1:0]       hdr_ready,
    input  eth_arb_pkg::mac_addr_t dest_mac [PORTS],
    input  eth_arb_pkg::mac_addr_t src_mac [PORTS],
    input  eth_arb_pkg::eth_type_t eth_type [PORTS],

    // Payload inputs
    input  eth_arb_pkg::data_t     payload_tdata [PORTS],
    input  eth_arb_pkg::keep_t     payload_tkeep [PORTS],
    input  logic [PORTS-1:0]       payload_tvalid,
    output logic [PORTS-1:0]       payload_tready,
    input  logic [PORTS-1:0]       payload_tlast,
    input  logic [PORTS-1:0]       payload_tuser,

    // Output
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output eth_arb_pkg::mac_addr_t out_dest_mac,
    output eth_arb_pkg::mac_addr_t out_src_mac,
    output eth_arb_pkg::eth_type_t out_eth_type,
    output eth_arb_pkg::data_t     out_payload_tdata,
    output eth_arb_pkg::keep_t     out_payload_tkeep,
    output logic                   out_payload_tvalid,
    input  logic                   out_payload_tready,
    output logic                   out_payload_tlast,
    output logic                   out_payload_tuser,

    // From the arbiter
    input  logic                   grant_valid,
    input  logic [SEL_W-1:0]       grant_index
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD
    } state_t;

    state_t state;

    logic hdr_room;
    logic pay_room;
    logic hdr_xfer;
    logic pay_xfer;

    // Output register empty or draining this cycle
    assign hdr_room = !out_hdr_valid || out_hdr_ready;
    assign pay_room = !out_payload_tvalid || out_payload_tready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input ready steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Both registers must have room in either phase, which keeps a new
    // header behind the previous last beat and the first beat behind its header
    always_comb begin
        hdr_ready      = '0;
        payload_tready = '0;
        if (grant_valid) begin
            hdr_ready[grant_index]      = (state == ST_HDR) && hdr_room && pay_room;
            payload_tready[grant_index] = (state == ST_PAYLOAD) && hdr_room && pay_room;
        end
    end

    assign hdr_xfer = hdr_valid[grant_index] && hdr_ready[grant_index];
    assign pay_xfer = payload_tvalid[grant_index] && payload_tready[grant_index];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_valid) begin
                        state <= ST_HDR;
                    end
                end
                // One header per grant
                ST_HDR: begin
                    if (hdr_xfer) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (pay_xfer && payload_tlast[grant_index]) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_hdr_valid      <= 1'b0;
            out_payload_tvalid <= 1'b0;
        end else begin
            if (hdr_xfer) begin
                out_hdr_valid <= 1'b1;
            end else if (out_hdr_ready) begin
                out_hdr_valid <= 1'b0;
            end
            if (pay_xfer) begin
                out_payload_tvalid <= 1'b1;
            end else if (out_payload_tready) begin
                out_payload_tvalid <= 1'b0;
            end
        end
    end

    // Fields only load on a transfer, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            out_dest_mac <= dest_mac[grant_index];
            out_src_mac  <= src_mac[grant_index];
            out_eth_type <= eth_type[grant_index];
        end
        if (pay_xfer) begin
            out_payload_tdata <= payload_tdata[grant_index];
            out_payload_tkeep <= payload_tkeep[grant_index];
            out_payload_tlast <= payload_tlast[grant_index];
            out_payload_tuser <= payload_tuser[grant_index];
        end
    end

endmodule

//--- source/eth_arb_mux.sv
`timescale 1ns/1ns

module eth_arb_mux #(
    parameter int                     PORTS    = 4,
    parameter eth_arb_pkg::arb_type_e ARB_TYPE = eth_arb_pkg::ARB_PRIORITY,
    localparam int                    SEL_W    = (PORTS > 1) ? $clog2(PORTS) : 1
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // Frame inputs, one entry per port
    input  logic [PORTS-1:0]       hdr_valid,
    output logic [PORTS-1:0]       hdr_ready,
    input  eth_arb_pkg::mac_addr_t dest_mac [PORTS],
    input  eth_arb_pkg::mac_addr_t src_mac [PORTS],
    input  eth_arb_pkg::eth_type_t eth_type [PORTS],
    input  eth_arb_pkg::data_t     payload_tdata [PORTS],
    input  eth_arb_pkg::keep_t     payload_tkeep [PORTS],
    input  logic [PORTS-1:0]       payload_tvalid,
    output logic [PORTS-1:0]       payload_tready,
    input  logic [PORTS-1:0]       payload_tlast,
    input  logic [PORTS-1:0]       payload_tuser,

    // Frame output
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output eth_arb_pkg::mac_addr_t out_dest_mac,
    output eth_arb_pkg::mac_addr_t out_src_mac,
    output eth_arb_pkg::eth_type_t out_eth_type,
    output eth_arb_pkg::data_t     out_payload_tdata,
    output eth_arb_pkg::keep_t     out_payload_tkeep,
    output logic                   out_payload_tvalid,
    input  logic                   out_payload_tready,
    output logic                   out_payload_tlast,
    output logic                   out_payload_tuser
);

    logic [PORTS-1:0] request;
    logic [PORTS-1:0] acknowledge;
    logic [PORTS-1:0] grant;
    logic             grant_valid;
    logic [SEL_W-1:0] grant_index;

    // A pending header asks for the output
    assign request     = hdr_valid;
    // Last payload beat accepted ends the frame
    assign acknowledge = payload_tvalid & payload_tready & payload_tlast;

    arbiter #(
        .PORTS    (PORTS),
        .ARB_TYPE (ARB_TYPE)
    ) arbiter_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    eth_mux #(
        .PORTS (PORTS)
    ) eth_mux_inst (
        .clk                (clk),
        .arst_n             (arst_n),
        .hdr_valid          (hdr_valid),
        .hdr_ready          (hdr_ready),
        .dest_mac           (dest_mac),
        .src_mac            (src_mac),
        .eth_type           (eth_type),
        .payload_tdata      (payload_tdata),
        .payload_tkeep      (payload_tkeep),
        .payload_tvalid     (payload_tvalid),
        .payload_tready     (payload_tready),
        .payload_tlast      (payload_tlast),
        .payload_tuser      (payload_tuser),
        .out_hdr_valid      (out_hdr_valid),
        .out_hdr_ready      (out_hdr_ready),
        .out_dest_mac       (out_dest_mac),
        .out_src_mac        (out_src_mac),
        .out_eth_type       (out_eth_type),
        .out_payload_tdata  (out_payload_tdata),
        .out_payload_tkeep  (out_payload_tkeep),
        .out_payload_tvalid (out_payload_tvalid),
        .out_payload_tready (out_payload_tready),
        .out_payload_tlast  (out_payload_tlast),
        .out_payload_tuser  (out_payload_tuser),
        .grant_valid        (grant_valid),
        .grant_index        (grant_index)
    );

endmodule

//--- verif/eth_arb_mux_assertions.sv
`timescale 1ns/1ns

module eth_arb_mux_assertions #(
    parameter int PORTS = 4
) (
    input logic                   clk,
    input logic                   arst_n,
    input logic [PORTS-1:0]       grant,
    input logic [PORTS-1:0]       acknowledge,
    input logic [PORTS-1:0]       hdr_ready,
    input logic [PORTS-1:0]       payload_tready,
    input logic                   out_hdr_valid,
    input logic                   out_hdr_ready,
    input eth_arb_pkg::mac_addr_t out_dest_mac,
    input eth_arb_pkg::mac_addr_t out_src_mac,
    input eth_arb_pkg::eth_type_t out_eth_type,
    input logic                   out_payload_tvalid,
    input logic                   out_payload_tready,
    input eth_arb_pkg::data_t     out_payload_tdata,
    input eth_arb_pkg::keep_t     out_payload_tkeep,
    input logic                   out_payload_tlast,
    input logic                   out_payload_tuser
);

    // One-hot grant, and the mux only opens the granted input
    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && (((hdr_ready | payload_tready) & ~grant) == '0))
        else $error("grant not one-hot or input ready outside the grant");

    // Held header under back-pressure
    hdr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_dest_mac)
            && $stable(out_src_mac) && $stable(out_eth_type))
        else $error("output header changed while stalled");

    pay_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_payload_tvalid && !out_payload_tready |=> out_payload_tvalid
            && $stable(out_payload_tdata) && $stable(out_payload_tkeep)
            && $stable(out_payload_tlast) && $stable(out_payload_tuser))
        else $error("output payload beat changed while stalled");

    grant_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (grant != '0) && !(|(acknowledge & grant)) |=> $stable(grant))
        else $error("grant changed without acknowledge");

endmodule

bind eth_arb_mux eth_arb_mux_assertions #(.PORTS(PORTS)) assertions_inst (.*);

//--- verif/eth_arb_mux_tb.sv
`timescale 1ns/1ns

module eth_arb_mux_tb #(
    parameter int ARB_MODE = 0
);

    localparam int NUM_GROUPS = 11;

    typedef struct {
        int                     port;
        int                     group;
        eth_arb_pkg::mac_addr_t dest;
        eth_arb_pkg::mac_addr_t src;
        eth_arb_pkg::eth_type_t etype;
        int                     beats;
        eth_arb_pkg::keep_t     last_keep;
        logic                   tuser;
    } frame_row_t;

    logic clk = 1'b0;
    logic arst_n;
    logic [3:0] hdr_valid;
    logic [3:0] hdr_ready;
    eth_arb_pkg::mac_addr_t dest_mac [4];
    eth_arb_pkg::mac_addr_t src_mac [4];
    eth_arb_pkg::eth_type_t eth_type [4];
    eth_arb_pkg::data_t payload_tdata [4];
    eth_arb_pkg::keep_t payload_tkeep [4];
    logic [3:0] payload_tvalid;
    logic [3:0] payload_tready;
    logic [3:0] payload_tlast;
    logic [3:0] payload_tuser;
    logic out_hdr_valid;
    logic out_hdr_ready;
    eth_arb_pkg::mac_addr_t out_dest_mac;
    eth_arb_pkg::mac_addr_t out_src_mac;
    eth_arb_pkg::eth_type_t out_eth_type;
    eth_arb_pkg::data_t out_payload_tdata;
    eth_arb_pkg::keep_t out_payload_tkeep;
    logic out_payload_tvalid;
    logic out_payload_tready;
    logic out_payload_tlast;
    logic out_payload_tuser;

    frame_row_t tbl [$];
    int exp_rows [$];
    bit sched [];
    int errors = 0;
    int cur_row = 0;
    int beat_idx = 0;
    bit in_frame = 0;
    bit bp_on = 0;
    bit built = 0;
    integer seed = 92467;

    always #2 clk = ~clk;

    eth_arb_mux #(
        .PORTS    (4),
        .ARB_TYPE (eth_arb_pkg::arb_type_e'(ARB_MODE))
    ) eth_arb_mux_inst (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame table and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_row(int port, int group, int beats, eth_arb_pkg::keep_t lk, logic tu);
        frame_row_t row;
        row.port      = port;
        row.group     = group;
        row.dest      = 48'h02_00_00_00_10_00 + 48'(tbl.size());
        row.src       = 48'h02_aa_00_00_00_00 + 48'(port * 256 + group);
        row.etype     = 16'h0800 + 16'(tbl.size());
        row.beats     = beats;
        row.last_keep = lk;
        row.tuser     = tu;
        tbl.push_back(row);
    endtask

    function automatic eth_arb_pkg::data_t beat_data(int r, int b);
        return {8'hda, 8'(r), 16'(b), 32'h5a5a_c3c3 ^ 32'(r * 977 + b)};
    endfunction

    function automatic eth_arb_pkg::keep_t beat_keep(int r, int b);
        return (b == tbl[r].beats - 1) ? tbl[r].last_keep : 8'hff;
    endfunction

    task automatic report_fail(string msg);
        errors++;
        $display("FAIL at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    // First row of a group on a port that is not yet in the expected order
    function automatic int next_row(int g, int p);
        for (int r = 0; r < tbl.size(); r++) begin
            if (tbl[r].group == g && tbl[r].port == p && !sched[r]) begin
                return r;
            end
        end
        return -1;
    endfunction

    // Expected output order from the arbitration rule
    task automatic build_expected(int num_groups);
        int last_win;
        int prev;
        int win;
        int p;
        int r;
        last_win = 0;
        sched = new[tbl.size()];
        for (int g = 0; g < num_groups; g++) begin
            prev = -1;
            do begin
                win = -1;
                // A port that just finished raises its next header too late
                // for the following decision, unless no other port waits
                for (int pass = 0; pass < 2 && win < 0; pass++) begin
                    for (int k = 0; k < 4; k++) begin
                        p = (ARB_MODE == 1) ? (last_win + 1 + k) % 4 : k;
                        if (win < 0 && next_row(g, p) >= 0 && (pass == 1 || p != prev)) begin
                            win = p;
                        end
                    end
                end
                if (win >= 0) begin
                    r = next_row(g, win);
                    sched[r] = 1'b1;
                    exp_rows.push_back(r);
                    last_win = win;
                    prev = win;
                end
            end while (win >= 0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_frame(int r);
        int  p;
        bit  ok;
        p = tbl[r].port;
        @(negedge clk);
        dest_mac[p]  = tbl[r].dest;
        src_mac[p]   = tbl[r].src;
        eth_type[p]  = tbl[r].etype;
        hdr_valid[p] = 1'b1;
        // Sample ready just before the rising edge
        do begin
            #1 ok = hdr_ready[p];
            @(negedge clk);
        end while (!ok);
        hdr_valid[p] = 1'b0;
        for (int b = 0; b < tbl[r].beats; b++) begin
            payload_tdata[p]  = beat_data(r, b);
            payload_tkeep[p]  = beat_keep(r, b);
            payload_tlast[p]  = (b == tbl[r].beats - 1);
            payload_tuser[p]  = (b == tbl[r].beats - 1) ? tbl[r].tuser : 1'b0;
            payload_tvalid[p] = 1'b1;
            do begin
                #1 ok = payload_tready[p];
                @(negedge clk);
            end while (!ok);
        end
        payload_tvalid[p] = 1'b0;
        payload_tlast[p]  = 1'b0;
    endtask

    // Frames of one port within a group go out back to back, in table order
    task automatic drive_port(int p, int g);
        for (int r = 0; r < tbl.size(); r++) begin
            if (tbl[r].group == g && tbl[r].port == p) begin
                drive_frame(r);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (arst_n) begin
            out_hdr_ready      <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
            out_payload_tready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
            #1;
            if (out_payload_tvalid && out_payload_tready) begin
                assert (in_frame) else report_fail("payload beat without header");
                assert (out_payload_tdata == beat_data(cur_row, beat_idx)
                        && out_payload_tkeep == beat_keep(cur_row, beat_idx))
                    else report_fail($sformatf("row %0d beat %0d data or keep", cur_row, beat_idx));
                assert (out_payload_tlast == (beat_idx == tbl[cur_row].beats - 1))
                    else report_fail($sformatf("row %0d beat %0d tlast", cur_row, beat_idx));
                assert (out_payload_tuser
                        == ((beat_idx == tbl[cur_row].beats - 1) && tbl[cur_row].tuser))
                    else report_fail($sformatf("row %0d beat %0d tuser", cur_row, beat_idx));
                beat_idx++;
                if (beat_idx == tbl[cur_row].beats) in_frame = 0;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                assert (!in_frame) else report_fail("header interleaved with a frame");
                assert (exp_rows.size() > 0) else report_fail("unexpected extra header");
                cur_row  = exp_rows.pop_front();
                beat_idx = 0;
                in_frame = 1;
                assert (out_dest_mac == tbl[cur_row].dest && out_src_mac == tbl[cur_row].src
                        && out_eth_type == tbl[cur_row].etype)
                    else report_fail($sformatf("header fields, expected row %0d", cur_row));
            end
        end
    end

    // Watchdog sized from the total beat count
    initial begin
        int total;
        total = 0;
        wait (built);
        foreach (tbl[r]) total += tbl[r].beats + 1;
        repeat (total * 40 + 200) @(posedge clk);
        $display("Timeout: the frames did not all come out in time");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        arst_n = 1'b0;
        hdr_valid = '0;
        payload_tvalid = '0;
        payload_tlast = '0;
        payload_tuser = '0;
        out_hdr_ready = 1'b0;
        out_payload_tready = 1'b0;
        for (int p = 0; p < 4; p++) begin
            dest_mac[p] = '0;
            src_mac[p] = '0;
            eth_type[p] = '0;
            payload_tdata[p] = '0;
            payload_tkeep[p] = '0;
        end
        // Single frames per port, then contended groups
        add_row(0, 0, 3, 8'h0f, 1'b0);
        add_row(1, 1, 1, 8'h01, 1'b1);
        add_row(2, 2, 4, 8'hff, 1'b0);
        add_row(3, 3, 2, 8'h7f, 1'b1);
        for (int g = 4; g < 6; g++) begin
            for (int p = 3; p >= 0; p--) add_row(p, g, p + 2, 8'h3f, p[0]);
        end
        add_row(3, 6, 3, 8'h03, 1'b0);
        add_row(1, 6, 2, 8'hff, 1'b1);
        add_row(2, 7, 2, 8'h1f, 1'b0);
        add_row(0, 7, 5, 8'hff, 1'b1);
        add_row(3, 7, 1, 8'h07, 1'b0);
        // Lone winner on port 1, then all four ports
        add_row(1, 8, 2, 8'h0f, 1'b0);
        for (int p = 0; p < 4; p++) begin
            add_row(p, 9, 2, 8'hff, p[1]);
        end
        // Port 0 requests again while another port holds the grant
        add_row(2, 10, 3, 8'h01, 1'b1);
        add_row(0, 10, 2, 8'hff, 1'b0);
        add_row(1, 10, 1, 8'h3f, 1'b0);
        add_row(0, 10, 2, 8'h0f, 1'b1);
        build_expected(NUM_GROUPS);
        built = 1;
        repeat (2) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            #1 assert (!out_hdr_valid && !out_payload_tvalid)
                else report_fail("output valid high before any frame");
        end
        for (int g = 0; g < NUM_GROUPS; g++) begin
            bp_on = (g >= 5);
            for (int p = 0; p < 4; p++) begin
                fork
                    automatic int pp = p;
                    automatic int gg = g;
                    drive_port(pp, gg);
                join_none
            end
            wait fork;
        end
        while (exp_rows.size() != 0 || in_frame) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- eth_arb_mux.f
source/eth_arb_pkg.sv
source/arbiter.sv
source/eth_mux.sv
source/eth_arb_mux.sv
verif/eth_arb_mux_assertions.sv
verif/eth_arb_mux_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench once per arbitration mode
set -e
cd "$(dirname "$0")"

for mode in 0 1; do
    rm -rf "build_${mode}"
    verilator --binary --timing --assert \
        -f eth_arb_mux.f \
        --top-module eth_arb_mux_tb \
        -GARB_MODE=${mode} \
        -Mdir "build_${mode}" -o sim
    # A failing run exits non-zero; the log search below decides the result
    "./build_${mode}/sim" > "sim_mode${mode}.log" 2>&1 || true
done

status=0
for mode in 0 1; do
    if grep -q "Simulation FAILED" "sim_mode${mode}.log"; then
        echo "Mode ${mode}: failure found in sim_mode${mode}.log"
        status=1
    else
        echo "Mode ${mode}: no failure in sim_mode${mode}.log"
    fi
done
exit ${status}
